//--- hw/cnn_post_pkg.sv
/* Convolution post-processing types */
`default_nettype none

package cnn_post_pkg;

    localparam int ACC_W  = 20;  // accumulator sum width
    localparam int PIX_W  = 8;
    localparam int ADDR_W = 10;  // feature-map address width

    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // one activated sample on its way into the pooling window
    typedef struct packed {
        logic  valid;
        logic  last;   // final sample of the frame
        pix_t  pix;
        addr_t addr;
    } act_beat_t;

    typedef struct packed {
        pix_t  pix;
        addr_t addr;   // address the window maximum came from
    } pool_pix_t;

endpackage

`default_nettype wire

//--- hw/relu_act.sv
/* Requantizing ReLU stage */
`default_nettype none

module relu_act #(
    parameter int ACT_SHIFT = 6
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                valid_i,
    input  wire logic                last_i,
    input  wire cnn_post_pkg::acc_t  data_i,
    input  wire cnn_post_pkg::addr_t addr_i,
    output cnn_post_pkg::act_beat_t  beat_o
);

    // largest sum that still fits a pixel after the shift
    localparam cnn_post_pkg::acc_t PIX_MAX =
        cnn_post_pkg::acc_t'((1 << cnn_post_pkg::PIX_W) - 1);

    cnn_post_pkg::acc_t  shifted;
    cnn_post_pkg::pix_t  pix_d;
    logic                valid_q;
    logic                last_q;
    cnn_post_pkg::pix_t  pix_q;
    cnn_post_pkg::addr_t addr_q;

    assign shifted = data_i >>> ACT_SHIFT;  // arithmetic, keeps the sign

    always_comb begin
        if (shifted[cnn_post_pkg::ACC_W-1]) begin
            pix_d = '0;  // relu
        end else if (shifted > PIX_MAX) begin
            pix_d = '1;  // saturate at 255
        end else begin
            pix_d = shifted[cnn_post_pkg::PIX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        last_q <= last_i;
        pix_q  <= pix_d;
        addr_q <= addr_i;
    end

    assign beat_o = '{valid: valid_q, last: last_q, pix: pix_q, addr: addr_q};

endmodule

`default_nettype wire

//--- hw/max_pool.sv
/* 2x2 max pooling window */
`default_nettype none

module max_pool (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire cnn_post_pkg::act_beat_t beat_i,
    output logic                         pool_valid_o,
    output logic                         pool_last_o,
    output cnn_post_pkg::pool_pix_t      pool_pix_o
);

    // one-hot, each state names the beat the window waits for
    typedef enum logic [3:0] {
        S_IDLE   = 4'b0001,
        S_SECOND = 4'b0010,
        S_THIRD  = 4'b0100,
        S_FOURTH = 4'b1000
    } state_e;

    state_e              state_q;
    state_e              state_d;
    cnn_post_pkg::pix_t  max_q;
    cnn_post_pkg::addr_t max_addr_q;
    logic                last_q;
    logic                new_max;

    // strict compare so the earliest address wins a tie
    assign new_max = beat_i.pix > max_q;

    always_comb begin
        state_d = S_IDLE;  // a missing beat drops the partial window
        if (beat_i.valid) begin
            case (state_q)
                S_IDLE:   state_d = S_SECOND;
                S_SECOND: state_d = S_THIRD;
                S_THIRD:  state_d = S_FOURTH;
                default:  state_d = S_IDLE;  // fourth beat closes the window
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            if (state_q == S_IDLE || new_max) begin
                max_q      <= beat_i.pix;
                max_addr_q <= beat_i.addr;
            end
            if (state_q == S_IDLE) begin
                last_q <= beat_i.last;  // first beat restarts the sticky flag
            end else begin
                last_q <= last_q | beat_i.last;
            end
        end
    end

    // result leaves in the same cycle as the fourth beat
    always_comb begin
        pool_valid_o = beat_i.valid && (state_q == S_FOURTH);
        pool_last_o  = pool_valid_o && (last_q || beat_i.last);
        if (new_max) begin
            pool_pix_o.pix  = beat_i.pix;
            pool_pix_o.addr = beat_i.addr;
        end else begin
            pool_pix_o.pix  = max_q;
            pool_pix_o.addr = max_addr_q;
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot(state_q))
        else $error("max_pool: window state left its legal encoding (%b)", state_q);

endmodule

`default_nettype wire

//--- hw/pool_result_buf.sv
/* Pooled result buffer */
`default_nettype none

module pool_result_buf #(
    parameter int BUF_DEPTH = 64
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           start_i,
    input  wire logic                           wr_valid_i,
    input  wire logic                           wr_last_i,
    input  wire cnn_post_pkg::pool_pix_t        wr_pix_i,
    input  wire logic [$clog2(BUF_DEPTH)-1:0]   rd_idx_i,
    output cnn_post_pkg::pool_pix_t             rd_data_o,
    output logic [$clog2(BUF_DEPTH + 1)-1:0]    count_o,
    output logic                                done_o
);

    localparam int IDX_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    cnn_post_pkg::pool_pix_t mem [BUF_DEPTH];
    logic [IDX_W-1:0]        wr_ptr_q;
    logic [CNT_W-1:0]        count_q;
    logic                    done_q;
    logic                    full;
    logic                    wr_en;

    assign full  = count_q == CNT_W'(BUF_DEPTH);
    assign wr_en = wr_valid_i && !full && !start_i;  // a new frame takes priority

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr_q <= '0;
            count_q  <= '0;
            done_q   <= 1'b0;
        end else if (start_i) begin
            wr_ptr_q <= '0;
            count_q  <= '0;
            done_q   <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                count_q  <= count_q + 1'b1;
            end
            // frame end is still flagged when its result is dropped on overflow
            if (wr_valid_i && wr_last_i) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_pix_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_idx_i];  // one cycle read latency
    end

    assign count_o = count_q;
    assign done_o  = done_q;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        (wr_valid_i && !start_i) |-> !full)
        else $error("pool_result_buf: result written while full, count %0d", count_q);

endmodule

`default_nettype wire

//--- hw/cnn_post_top.sv
/* Convolution post-processing top */
`default_nettype none

module cnn_post_top #(
    parameter int ACT_SHIFT = 6,
    parameter int BUF_DEPTH = 64
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         acc_valid_i,
    input  wire logic                         acc_last_i,
    input  wire cnn_post_pkg::acc_t           acc_data_i,
    input  wire cnn_post_pkg::addr_t          acc_addr_i,
    input  wire logic                         start_i,
    input  wire logic [$clog2(BUF_DEPTH)-1:0] rd_idx_i,
    output cnn_post_pkg::pool_pix_t           rd_data_o,
    output logic [$clog2(BUF_DEPTH + 1)-1:0]  count_o,
    output logic                              done_o
);

    cnn_post_pkg::act_beat_t act_beat;
    logic                    pool_valid;
    logic                    pool_last;
    cnn_post_pkg::pool_pix_t pool_pix;

    relu_act #(
        .ACT_SHIFT (ACT_SHIFT)
    ) u_act (
        .clk     (clk),
        .rst     (rst),
        .valid_i (acc_valid_i),
        .last_i  (acc_last_i),
        .data_i  (acc_data_i),
        .addr_i  (acc_addr_i),
        .beat_o  (act_beat)
    );

    // combinational from the fourth beat, so the write lands one edge after the input
    max_pool u_pool (
        .clk          (clk),
        .rst          (rst),
        .beat_i       (act_beat),
        .pool_valid_o (pool_valid),
        .pool_last_o  (pool_last),
        .pool_pix_o   (pool_pix)
    );

    pool_result_buf #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buf (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .wr_valid_i (pool_valid),
        .wr_last_i  (pool_last),
        .wr_pix_i   (pool_pix),
        .rd_idx_i   (rd_idx_i),
        .rd_data_o  (rd_data_o),
        .count_o    (count_o),
        .done_o     (done_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_cnn_post.sv
/* Post-processing testbench */
`default_nettype none

module tb_cnn_post;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 8;
    localparam int SEED       = 37653;
    localparam int ACT_SHIFT  = 6;
    localparam int BUF_DEPTH  = 64;
    localparam int IDX_W      = $clog2(BUF_DEPTH);
    localparam int CNT_W      = $clog2(BUF_DEPTH + 1);
    localparam int DONE_WAIT  = 10;  // cycles allowed from the final sample to done_o

    localparam int ACT_CYCLES    = 120;
    localparam int MAX_CYCLES    = 150;
    localparam int GAP_CYCLES    = 120;
    localparam int FRAME_CYCLES  = 200;
    localparam int RAND_CYCLES   = 1200;  // three frames of up to 40 windows
    localparam int MARGIN_CYCLES = 500;
    localparam int WATCHDOG_NS   = (RST_CYCLES + ACT_CYCLES + MAX_CYCLES + GAP_CYCLES
                                    + FRAME_CYCLES + RAND_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        logic                gap;   // idle cycle in front of this sample
        logic                last;
        cnn_post_pkg::acc_t  sum;
        cnn_post_pkg::addr_t addr;
    } sample_t;

    logic                    clk;
    logic                    rst;
    logic                    acc_valid_i;
    logic                    acc_last_i;
    cnn_post_pkg::acc_t      acc_data_i;
    cnn_post_pkg::addr_t     acc_addr_i;
    logic                    start_i;
    logic [IDX_W-1:0]        rd_idx_i;
    cnn_post_pkg::pool_pix_t rd_data_o;
    logic [CNT_W-1:0]        count_o;
    logic                    done_o;

    sample_t                 stim_q[$];
    cnn_post_pkg::pool_pix_t exp_q[$];  // results expected in the buffer, in order
    logic                    exp_done;

    cnn_post_top u_cnn_post_top (
        .clk         (clk),
        .rst         (rst),
        .acc_valid_i (acc_valid_i),
        .acc_last_i  (acc_last_i),
        .acc_data_i  (acc_data_i),
        .acc_addr_i  (acc_addr_i),
        .start_i     (start_i),
        .rd_idx_i    (rd_idx_i),
        .rd_data_o   (rd_data_o),
        .count_o     (count_o),
        .done_o      (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pix(input string name, input cnn_post_pkg::pool_pix_t expected,
                             input cnn_post_pkg::pool_pix_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected pix %0d addr %0d, actual pix %0d addr %0d",
                                     name, expected.pix, expected.addr, actual.pix, actual.addr));
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] expected,
                               input logic [CNT_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected count %0d, actual count %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected done %b, actual done %b",
                                     name, expected, actual));
        end
    endtask

    // shift, relu, then saturate to the pixel range
    function automatic cnn_post_pkg::pix_t act_pixel(input cnn_post_pkg::acc_t sum);
        int v;
        v = int'(sum) >>> ACT_SHIFT;
        if (v < 0) begin
            return '0;
        end
        if (v > 255) begin
            return 8'd255;
        end
        return cnn_post_pkg::pix_t'(v);
    endfunction

    function automatic void predict_results();
        int                      fill;
        logic                    win_last;
        cnn_post_pkg::pix_t      p;
        cnn_post_pkg::pool_pix_t best;
        fill     = 0;
        win_last = 1'b0;
        best     = '0;
        foreach (stim_q[i]) begin
            p = act_pixel(stim_q[i].sum);
            if (stim_q[i].gap) begin
                fill = 0;  // the partial window is lost
            end
            if (fill == 0) begin
                best.pix  = p;
                best.addr = stim_q[i].addr;
                win_last  = stim_q[i].last;
            end else begin
                if (p > best.pix) begin
                    best.pix  = p;
                    best.addr = stim_q[i].addr;
                end
                win_last = win_last | stim_q[i].last;
            end
            fill++;
            if (fill == 4) begin
                exp_q.push_back(best);
                if (win_last) begin
                    exp_done = 1'b1;
                end
                fill = 0;
            end
        end
    endfunction

    task automatic add_sample(input logic gap, input logic last, input int sum, input int addr);
        stim_q.push_back('{gap: gap, last: last, sum: cnn_post_pkg::acc_t'(sum),
                           addr: cnn_post_pkg::addr_t'(addr)});
    endtask

    task automatic add_window(input logic gap, input int s0, input int s1, input int s2,
                              input int s3, input int base, input logic last);
        add_sample(gap, 1'b0, s0, base);
        add_sample(1'b0, 1'b0, s1, base + 1);
        add_sample(1'b0, 1'b0, s2, base + 2);
        add_sample(1'b0, last, s3, base + 3);
    endtask

    task automatic sends_frame();
        foreach (stim_q[i]) begin
            if (stim_q[i].gap) begin
                @(posedge clk);
                acc_valid_i <= 1'b0;
                acc_last_i  <= 1'b0;
            end
            @(posedge clk);
            acc_valid_i <= 1'b1;
            acc_last_i  <= stim_q[i].last;
            acc_data_i  <= stim_q[i].sum;
            acc_addr_i  <= stim_q[i].addr;
        end
        @(posedge clk);
        acc_valid_i <= 1'b0;
        acc_last_i  <= 1'b0;
        stim_q.delete();
    endtask

    task automatic run_frame();
        predict_results();
        sends_frame();
    endtask

    task automatic clear_buffer();
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        exp_q.delete();
        exp_done = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done_o && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done_o) begin
            report_failure($sformatf("%s: done_o did not rise within %0d cycles of the last sample",
                                     name, DONE_WAIT));
        end
    endtask

    task automatic read_result(input logic [IDX_W-1:0] idx,
                               output cnn_post_pkg::pool_pix_t data);
        @(posedge clk);
        rd_idx_i <= idx;
        @(posedge clk);
        @(negedge clk);
        data = rd_data_o;  // registered read port
    endtask

    task automatic verify_buffer(input string name);
        cnn_post_pkg::pool_pix_t got;
        if (exp_done) begin
            wait_done(name);
        end else begin
            repeat (4) @(negedge clk);
        end
        check_count(name, CNT_W'(exp_q.size()), count_o);
        check_done(name, exp_done, done_o);
        foreach (exp_q[i]) begin
            read_result(IDX_W'(i), got);
            check_pix($sformatf("%s entry %0d", name, i), exp_q[i], got);
        end
    endtask

    task automatic activation_test();
        clear_buffer();
        add_window(1'b0, -524288, -64, -1, -100, 16, 1'b0);
        add_window(1'b0, 1000, 6405, 63, 128, 32, 1'b0);
        add_window(1'b0, 16319, 16320, 20000, 524287, 48, 1'b0);  // 254 then three 255s
        add_window(1'b0, 200, 191, 64, 127, 64, 1'b1);
        run_frame();
        verify_buffer("activation");
    endtask

    task automatic max_address_test();
        int pos;
        int k;
        clear_buffer();
        for (pos = 0; pos < 4; pos++) begin
            for (k = 0; k < 4; k++) begin
                add_sample(1'b0, 1'b0, (k == pos) ? 12800 : 640, 100 + 8 * pos + k);
            end
        end
        add_window(1'b0, 640, 640, 640, 640, 200, 1'b0);
        add_window(1'b0, 640, 3200, 3200, 1280, 300, 1'b1);  // tie between the middle beats
        run_frame();
        verify_buffer("max and address");
    endtask

    task automatic gap_test();
        clear_buffer();
        add_window(1'b0, 640, 1280, 1920, 2560, 0, 1'b0);
        add_sample(1'b0, 1'b0, 6400, 10);
        add_sample(1'b0, 1'b0, 6400, 11);
        add_window(1'b1, 320, 960, 640, 64, 20, 1'b0);
        add_sample(1'b0, 1'b0, 12800, 30);
        add_sample(1'b0, 1'b0, 12800, 31);
        add_sample(1'b0, 1'b0, 12800, 32);
        add_window(1'b1, 3200, 3840, 2560, 1920, 40, 1'b1);
        run_frame();
        verify_buffer("gaps");
    endtask

    task automatic frame_control_test();
        clear_buffer();
        add_window(1'b0, 640, 1280, 64, 128, 0, 1'b0);
        add_window(1'b0, 5000, 300, 900, 4100, 4, 1'b0);
        add_window(1'b0, -64, 70, 8000, 90, 8, 1'b0);
        run_frame();
        verify_buffer("frame without last");
        add_window(1'b0, 100, 200, 300, 400, 12, 1'b1);
        run_frame();
        verify_buffer("frame with last");
        clear_buffer();
        @(negedge clk);
        check_count("after start", '0, count_o);
        check_done("after start", 1'b0, done_o);
        add_window(1'b0, 9000, 9600, 9100, 128, 500, 1'b0);
        add_sample(1'b0, 1'b0, 64, 504);
        add_sample(1'b0, 1'b1, 256, 505);  // last arrives before the window closes
        add_sample(1'b0, 1'b0, 512, 506);
        add_sample(1'b0, 1'b0, 1024, 507);
        run_frame();
        verify_buffer("second frame");
    endtask

    task automatic random_frames_test();
        int   f;
        int   w;
        int   k;
        int   n_win;
        int   sum;
        logic gap;
        logic tie;
        for (f = 0; f < 3; f++) begin
            clear_buffer();
            n_win = int'($urandom_range(40, 4));
            for (w = 0; w < n_win; w++) begin
                gap = ($urandom_range(3, 0) == 0);
                tie = ($urandom_range(4, 0) == 0);
                for (k = 0; k < 4; k++) begin
                    if (tie) begin
                        sum = int'($urandom_range(3, 0)) * 64;  // few values, so ties happen
                    end else begin
                        sum = int'($urandom_range(24095, 0)) - 4096;
                    end
                    add_sample(gap && (k == 0), (w == n_win - 1) && (k == 3), sum,
                               int'($urandom_range(1023, 0)));
                end
            end
            run_frame();
            verify_buffer($sformatf("random frame %0d", f));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b0;
        acc_valid_i = 1'b0;
        acc_last_i  = 1'b0;
        acc_data_i  = '0;
        acc_addr_i  = '0;
        start_i     = 1'b0;
        rd_idx_i    = '0;
        exp_done    = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_count("reset", '0, count_o);
        check_done("reset", 1'b0, done_o);
        activation_test();
        max_address_test();
        gap_test();
        frame_control_test();
        random_frames_test();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/cnn_post_pkg.sv
hw/relu_act.sv
hw/max_pool.sv
hw/pool_result_buf.sv
hw/cnn_post_top.sv
tests/tb_cnn_post.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cnn_post -f compile.f -o tb_cnn_post
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_cnn_post 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    echo "simulation passed"
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi
